// File: Bender.yml
package:
  name: spi_resp_arbiter

sources:
  - arbiter_router_pkg.sv
  - response_queue.sv
  - packet_disassembler.sv
  - arbiter_router_arbiter.sv
  - spi_minion_tx.sv
  - spi_resp_arbiter.sv
  - target: test
    files:
      - spi_resp_arbiter_tb.sv

// File: arbiter_router_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module arbiter_router_arbiter (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       istream_val [arbiter_router_pkg::NUM_SOURCES],
  output logic                       istream_rdy [arbiter_router_pkg::NUM_SOURCES],
  input  arbiter_router_pkg::chunk_t istream_msg [arbiter_router_pkg::NUM_SOURCES],
  output logic                       ostream_val,
  input  logic                       ostream_rdy,
  output arbiter_router_pkg::frame_t ostream_msg
);
  import arbiter_router_pkg::*;

  src_addr_t grant;
  src_addr_t prev_grant;
  src_addr_t encoder_out;

  // lowest index wins, so scan from the top down and let lower
  // valid inputs overwrite the result
  always_comb begin
    encoder_out = '0;
    for (int i = NUM_SOURCES - 1; i >= 0; i--) begin
      if (istream_val[i]) begin
        encoder_out = src_addr_t'(i);
      end
    end
  end

  // the grant sticks to the previous winner while its val stays high
  // which keeps the chunks of one message together
  // a disassembler drops val for a cycle after its last chunk and that
  // is what frees the grant for the encoder
  always_comb begin
    if (!istream_val[prev_grant]) begin
      grant = encoder_out;
    end else begin
      grant = prev_grant;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prev_grant <= '0;
    end else begin
      prev_grant <= grant;
    end
  end

  // downstream sees the granted input only
  assign ostream_val = istream_val[grant];

  // the source index is placed in front of the chunk
  always_comb begin
    ostream_msg.addr = grant;
    ostream_msg.data = istream_msg[grant];
  end

  // every input other than the granted one is held off
  always_comb begin
    for (int i = 0; i < NUM_SOURCES; i++) begin
      if (grant == src_addr_t'(i)) begin
        istream_rdy[i] = ostream_rdy;
      end else begin
        istream_rdy[i] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: arbiter_router_pkg.sv
`default_nettype none

package arbiter_router_pkg;

  // three on-chip sources share the single SPI return path
  localparam int NUM_SOURCES = 3;

  // a response is one full word, cut into byte-sized chunks for SPI
  localparam int DATA_NBITS  = 32;
  localparam int CHUNK_NBITS = 8;
  localparam int NUM_CHUNKS  = DATA_NBITS / CHUNK_NBITS;

  // each frame on the wire carries the source index above the chunk
  localparam int ADDR_NBITS  = $clog2(NUM_SOURCES);
  localparam int FRAME_NBITS = ADDR_NBITS + CHUNK_NBITS;

  // one SPI transaction shifts a valid flag ahead of the frame
  localparam int SPI_NBITS = FRAME_NBITS + 1;

  // response queue sizing
  localparam int QUEUE_DEPTH     = 2;
  localparam int QUEUE_PTR_NBITS = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_NBITS = $clog2(QUEUE_DEPTH + 1);

  // counter widths for the chunk index and the SPI bit position
  localparam int CHUNK_IDX_NBITS = $clog2(NUM_CHUNKS);
  localparam int SPI_CNT_NBITS   = $clog2(SPI_NBITS);

  typedef logic [DATA_NBITS-1:0]  data_t;
  typedef logic [CHUNK_NBITS-1:0] chunk_t;
  typedef logic [ADDR_NBITS-1:0]  src_addr_t;

  // address sits in the upper bits so it leaves the minion first
  typedef struct packed {
    src_addr_t addr;
    chunk_t    data;
  } frame_t;

  typedef enum logic [1:0] {DS_IDLE, DS_SEND, DS_GAP} disasm_state_e;

  typedef enum logic [1:0] {TX_IDLE, TX_SHIFT, TX_DONE} tx_state_e;

endpackage

`default_nettype wire

// File: packet_disassembler.sv
`timescale 1ns/1ps
`default_nettype none

module packet_disassembler (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  output logic                       req_rdy,
  input  arbiter_router_pkg::data_t  req_msg,
  output logic                       chunk_val,
  input  logic                       chunk_rdy,
  output arbiter_router_pkg::chunk_t chunk_msg
);
  import arbiter_router_pkg::*;

  disasm_state_e              state;
  data_t                      data_q;
  logic [CHUNK_IDX_NBITS-1:0] chunk_idx;
  logic                       take_req;
  logic                       take_chunk;
  logic                       last_chunk;

  // a new response is only accepted when nothing is in flight
  assign req_rdy = (state == DS_IDLE);

  // val stays high for every chunk of a message with no hole inside it
  assign chunk_val = (state == DS_SEND);

  // the register is shifted left after each chunk, so the top byte is
  // always the next one to go out
  assign chunk_msg = data_q[DATA_NBITS-1 -: CHUNK_NBITS];

  assign take_req   = req_val && req_rdy;
  assign take_chunk = chunk_val && chunk_rdy;
  assign last_chunk = (chunk_idx == CHUNK_IDX_NBITS'(NUM_CHUNKS - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= DS_IDLE;
      chunk_idx <= '0;
    end else begin
      case (state)
        DS_IDLE: begin
          if (take_req) begin
            state     <= DS_SEND;
            chunk_idx <= '0;
          end
        end
        DS_SEND: begin
          if (take_chunk) begin
            if (last_chunk) begin
              state <= DS_GAP;
            end else begin
              chunk_idx <= chunk_idx + 1'b1;
            end
          end
        end
        // one cycle with val low lets the arbiter drop its sticky grant
        DS_GAP: begin
          state <= DS_IDLE;
        end
        default: begin
          state <= DS_IDLE;
        end
      endcase
    end
  end

  // payload register, loaded on accept and shifted on every taken chunk
  always_ff @(posedge clk) begin
    if (take_req) begin
      data_q <= req_msg;
    end else if (take_chunk) begin
      data_q <= {data_q[DATA_NBITS-CHUNK_NBITS-1:0], {CHUNK_NBITS{1'b0}}};
    end
  end

endmodule

`default_nettype wire

// File: response_queue.sv
`timescale 1ns/1ps
`default_nettype none

module response_queue (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      in_val,
  output logic                      in_rdy,
  input  arbiter_router_pkg::data_t in_msg,
  output logic                      out_val,
  input  logic                      out_rdy,
  output arbiter_router_pkg::data_t out_msg
);
  import arbiter_router_pkg::*;

  data_t                      mem [QUEUE_DEPTH];
  logic [QUEUE_PTR_NBITS-1:0] wr_ptr;
  logic [QUEUE_PTR_NBITS-1:0] rd_ptr;
  logic [QUEUE_CNT_NBITS-1:0] count;
  logic                       push;
  logic                       pop;

  // space is judged from the count only, so in_rdy never waits on out_rdy
  assign in_rdy  = (count < QUEUE_CNT_NBITS'(QUEUE_DEPTH));
  assign out_val = (count != '0);
  assign out_msg = mem[rd_ptr];

  assign push = in_val && in_rdy;
  assign pop  = out_val && out_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // write pointer wraps at the last slot
      if (push) begin
        if (wr_ptr == QUEUE_PTR_NBITS'(QUEUE_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr == QUEUE_PTR_NBITS'(QUEUE_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      // a push and a pop in the same cycle leave the count unchanged
      count <= count + QUEUE_CNT_NBITS'(push) - QUEUE_CNT_NBITS'(pop);
    end
  end

  // each accepted word goes into the slot under the write pointer
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_msg;
    end
  end

endmodule

`default_nettype wire

// File: spi_minion_tx.sv
`timescale 1ns/1ps
`default_nettype none

module spi_minion_tx (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       sclk,
  input  logic                       cs_n,
  output logic                       miso,
  input  logic                       frame_val,
  output logic                       frame_rdy,
  input  arbiter_router_pkg::frame_t frame_msg
);
  import arbiter_router_pkg::*;

  logic                     sclk_sync1;
  logic                     sclk_sync2;
  logic                     sclk_prev;
  logic                     cs_sync1;
  logic                     cs_sync2;
  logic                     cs_prev;
  logic                     sclk_fall;
  logic                     cs_fall;
  logic                     cs_rise;
  tx_state_e                state;
  logic [SPI_NBITS-1:0]     shift_q;
  logic [SPI_CNT_NBITS-1:0] bit_cnt;

  // sclk and cs_n come from the external master with no relation to clk
  // so both pass two flops before any edge is looked at
  // cs_n idles high, so its chain comes out of reset high as well
  always_ff @(posedge clk) begin
    if (reset) begin
      sclk_sync1 <= 1'b0;
      sclk_sync2 <= 1'b0;
      sclk_prev  <= 1'b0;
      cs_sync1   <= 1'b1;
      cs_sync2   <= 1'b1;
      cs_prev    <= 1'b1;
    end else begin
      sclk_sync1 <= sclk;
      sclk_sync2 <= sclk_sync1;
      sclk_prev  <= sclk_sync2;
      cs_sync1   <= cs_n;
      cs_sync2   <= cs_sync1;
      cs_prev    <= cs_sync2;
    end
  end

  assign sclk_fall = sclk_prev && !sclk_sync2;
  assign cs_fall   = cs_prev && !cs_sync2;
  assign cs_rise   = !cs_prev && cs_sync2;

  // a frame is pulled in the single cycle where the start of a
  // transaction is seen, whether or not one is waiting
  assign frame_rdy = (state == TX_IDLE) && cs_fall;

  // the flag bit leaves first, then address, then chunk
  assign miso = shift_q[SPI_NBITS-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= TX_IDLE;
      shift_q <= '0;
      bit_cnt <= '0;
    end else if (cs_rise) begin
      // a cs_n rise ends the transaction and also aborts a short one
      state   <= TX_IDLE;
      shift_q <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (cs_fall) begin
            // nothing pending means an all zero word with the flag clear
            shift_q <= frame_val ? {1'b1, frame_msg} : '0;
            bit_cnt <= '0;
            state   <= TX_SHIFT;
          end
        end
        TX_SHIFT: begin
          // in mode 0 the master samples on the rise so miso moves on the fall
          if (sclk_fall) begin
            shift_q <= {shift_q[SPI_NBITS-2:0], 1'b0};
            if (bit_cnt == SPI_CNT_NBITS'(SPI_NBITS - 1)) begin
              state <= TX_DONE;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        // all bits are out so wait here for cs_n to go high
        TX_DONE: begin
          state <= TX_DONE;
        end
        default: begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: spi_resp_arbiter.f
arbiter_router_pkg.sv
response_queue.sv
packet_disassembler.sv
arbiter_router_arbiter.sv
spi_minion_tx.sv
spi_resp_arbiter.sv
spi_resp_arbiter_tb.sv

// File: spi_resp_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_resp_arbiter (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      resp_val [arbiter_router_pkg::NUM_SOURCES],
  output logic                      resp_rdy [arbiter_router_pkg::NUM_SOURCES],
  input  arbiter_router_pkg::data_t resp_msg [arbiter_router_pkg::NUM_SOURCES],
  input  logic                      sclk,
  input  logic                      cs_n,
  output logic                      miso
);
  import arbiter_router_pkg::*;

  // queue to disassembler streams
  logic   q_val [NUM_SOURCES];
  logic   q_rdy [NUM_SOURCES];
  data_t  q_msg [NUM_SOURCES];

  // disassembler to arbiter streams
  logic   chunk_val [NUM_SOURCES];
  logic   chunk_rdy [NUM_SOURCES];
  chunk_t chunk_msg [NUM_SOURCES];

  // arbiter to SPI transmitter
  logic   frame_val;
  logic   frame_rdy;
  frame_t frame_msg;

  // one queue and one disassembler per source
  for (genvar i = 0; i < NUM_SOURCES; i++) begin : g_source
    response_queue i_response_queue (
      .clk     (clk),
      .reset   (reset),
      .in_val  (resp_val[i]),
      .in_rdy  (resp_rdy[i]),
      .in_msg  (resp_msg[i]),
      .out_val (q_val[i]),
      .out_rdy (q_rdy[i]),
      .out_msg (q_msg[i])
    );

    packet_disassembler i_packet_disassembler (
      .clk       (clk),
      .reset     (reset),
      .req_val   (q_val[i]),
      .req_rdy   (q_rdy[i]),
      .req_msg   (q_msg[i]),
      .chunk_val (chunk_val[i]),
      .chunk_rdy (chunk_rdy[i]),
      .chunk_msg (chunk_msg[i])
    );
  end

  arbiter_router_arbiter i_arbiter (
    .clk         (clk),
    .reset       (reset),
    .istream_val (chunk_val),
    .istream_rdy (chunk_rdy),
    .istream_msg (chunk_msg),
    .ostream_val (frame_val),
    .ostream_rdy (frame_rdy),
    .ostream_msg (frame_msg)
  );

  spi_minion_tx i_spi_minion_tx (
    .clk       (clk),
    .reset     (reset),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .miso      (miso),
    .frame_val (frame_val),
    .frame_rdy (frame_rdy),
    .frame_msg (frame_msg)
  );

endmodule

`default_nettype wire

// File: spi_resp_arbiter_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_resp_arbiter_tb;
  import arbiter_router_pkg::*;

  localparam int CLK_PERIOD_NS  = 4;
  localparam int RESET_CYCLES   = 3;
  // each sclk level lasts this many clk cycles, above the minion's minimum of 6
  localparam int SCLK_HOLD      = 8;
  localparam int CYCLES_PER_REC = 256;
  localparam int RDY_WATCH      = 16;

  logic  clk;
  logic  reset;
  logic  resp_val [NUM_SOURCES];
  logic  resp_rdy [NUM_SOURCES];
  data_t resp_msg [NUM_SOURCES];
  logic  sclk;
  logic  cs_n;
  logic  miso;

  // one entry per record of the stimulus file with comment lines dropped
  logic [7:0]  rec_code [$];
  logic [31:0] rec_a [$];
  logic [31:0] rec_b [$];

  int cycle_count = 0;
  int cycle_limit = 0;

  spi_resp_arbiter i_spi_resp_arbiter (
    .clk      (clk),
    .reset    (reset),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .miso     (miso)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
  end

  // the limit stays at zero until the records have been counted
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit + RESET_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_frame(input frame_t got, input frame_t exp, input string name);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got addr %0d data %02h, expected addr %0d data %02h",
               $time, name, got.addr, got.data, exp.addr, exp.data);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_rdy(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // byte j of push k to source src is 0x10*(j+1) + 4*src + k with the top byte first
  function automatic data_t pattern_word(input int src, input int k);
    data_t word;
    word = '0;
    for (int j = 0; j < NUM_CHUNKS; j++) begin
      word = {word[DATA_NBITS-CHUNK_NBITS-1:0], chunk_t'(16 * (j + 1) + 4 * src + k)};
    end
    return word;
  endfunction

  // starts on a falling edge and returns on the falling edge after the handshake
  task automatic push_response(input int src, input data_t data);
    resp_val[src] = 1'b1;
    resp_msg[src] = data;
    // resp_rdy comes from the queue count, so it is settled at the falling edge
    while (resp_rdy[src] !== 1'b1) begin
      @(negedge clk);
    end
    @(negedge clk);
    resp_val[src] = 1'b0;
  endtask

  task automatic push_burst(input int src, input int count);
    logic exp_rdy;
    // with no reads the disassembler holds one response and the queue the rest
    exp_rdy = (count < QUEUE_DEPTH + 1);
    for (int k = 0; k < count; k++) begin
      push_response(src, pattern_word(src, k));
    end
    repeat (4) @(negedge clk);
    repeat (RDY_WATCH) begin
      check_rdy(resp_rdy[src], exp_rdy, $sformatf("resp_rdy[%0d]", src));
      @(negedge clk);
    end
  endtask

  // one mode 0 transaction of SPI_NBITS bits, flag first
  task automatic spi_transfer(output logic flag, output frame_t frame);
    logic [SPI_NBITS-1:0] bits;
    bits = '0;
    cs_n = 1'b0;
    repeat (SCLK_HOLD) @(negedge clk);
    for (int b = 0; b < SPI_NBITS; b++) begin
      // miso is taken as sclk rises
      bits = {bits[SPI_NBITS-2:0], miso};
      sclk = 1'b1;
      repeat (SCLK_HOLD) @(negedge clk);
      sclk = 1'b0;
      repeat (SCLK_HOLD) @(negedge clk);
    end
    cs_n = 1'b1;
    repeat (SCLK_HOLD) @(negedge clk);
    flag  = bits[SPI_NBITS-1];
    frame = bits[FRAME_NBITS-1:0];
  endtask

  task automatic load_records();
    int               fd;
    int               n;
    int               want;
    logic [7:0]       code;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [8*128-1:0] rest;
    fd = $fopen("spi_resp_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file spi_resp_stim.txt");
      abort_run();
    end
    while ($fscanf(fd, " %c", code) == 1) begin
      a = '0;
      b = '0;
      case (code)
        "#": n = $fgets(rest, fd);
        "P": n = $fscanf(fd, "%d %h", a, b);
        "F": n = $fscanf(fd, "%h %h", a, b);
        "B": n = $fscanf(fd, "%d %d", a, b);
        "W": n = $fscanf(fd, "%d", a);
        "E": n = 0;
        default: begin
          $display("unknown record code %c in the stimulus file", code);
          abort_run();
        end
      endcase
      case (code)
        "P", "F", "B": want = 2;
        "W":           want = 1;
        default:       want = 0;
      endcase
      if (code != "#") begin
        if (n != want) begin
          $display("record %c in the stimulus file is missing a field", code);
          abort_run();
        end
        rec_code.push_back(code);
        rec_a.push_back(a);
        rec_b.push_back(b);
      end
    end
    $fclose(fd);
  endtask

  initial begin : main_sequence
    logic   flag;
    frame_t frame;
    frame_t exp_frame;
    reset = 1'b1;
    sclk  = 1'b0;
    cs_n  = 1'b1;
    for (int i = 0; i < NUM_SOURCES; i++) begin
      resp_val[i] = 1'b0;
      resp_msg[i] = '0;
    end
    load_records();
    cycle_limit = CYCLES_PER_REC * rec_code.size();
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    for (int r = 0; r < rec_code.size(); r++) begin
      case (rec_code[r])
        "P": push_response(int'(rec_a[r]), rec_b[r]);
        "B": push_burst(int'(rec_a[r]), int'(rec_b[r]));
        "W": repeat (rec_a[r]) @(negedge clk);
        "E": begin
          spi_transfer(flag, frame);
          check_flag(flag, 1'b0, "miso flag");
          check_frame(frame, '0, "miso frame");
        end
        // only F is left since the loader has already rejected anything else
        default: begin
          spi_transfer(flag, frame);
          exp_frame.addr = src_addr_t'(rec_a[r]);
          exp_frame.data = chunk_t'(rec_b[r]);
          check_flag(flag, 1'b1, "miso flag");
          check_frame(frame, exp_frame, "miso frame");
        end
      endcase
    end
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: spi_resp_stim.txt
# P src data pushes one response, F addr chunk expects a frame, E expects an empty frame
# B src count pushes pattern words and checks resp_rdy, W cycles waits
# idle read before anything is pushed
E
W 8
# one response split into four frames
P 1 a1b2c3d4
F 1 a1
F 1 b2
F 1 c3
F 1 d4
E
# sources 0 and 2 one at a time
P 0 0badcafe
F 0 0b
F 0 ad
F 0 ca
F 0 fe
P 2 12345678
F 2 12
F 2 34
F 2 56
F 2 78
# all three pending, lowest index first
P 0 deadbeef
P 1 cafef00d
P 2 87654321
F 0 de
F 0 ad
F 0 be
F 0 ef
F 1 ca
F 1 fe
F 1 f0
F 1 0d
F 2 87
F 2 65
F 2 43
F 2 21
# two per source, whole messages only
B 0 2
B 1 2
B 2 2
F 0 10
F 0 20
F 0 30
F 0 40
F 1 14
F 1 24
F 1 34
F 1 44
F 0 11
F 0 21
F 0 31
F 0 41
F 1 15
F 1 25
F 1 35
F 1 45
F 2 18
F 2 28
F 2 38
F 2 48
F 2 19
F 2 29
F 2 39
F 2 49
E
# back-pressure on source 2
B 2 3
F 2 18
F 2 28
F 2 38
F 2 48
F 2 19
F 2 29
F 2 39
F 2 49
F 2 1a
F 2 2a
F 2 3a
F 2 4a
B 2 0
E
